// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

   // instruction field widths
   localparam int NB_INSTR     = 32;
   localparam int NB_OPCODE    = 6;
   localparam int NB_FUNCT     = 6;
   localparam int NB_REG_IDX   = 5;
   localparam int NB_IMM       = 16;
   localparam int NB_INDEX     = 26;
   localparam int NB_SHAMT     = 5;
   localparam int NB_JUMP_KEEP = 28; // low target bits taken from index << 2

   // field positions, lsb of each
   localparam int OPCODE_LSB = 26;
   localparam int RS_LSB     = 21;
   localparam int RT_LSB     = 16;
   localparam int RD_LSB     = 11;
   localparam int SHAMT_LSB  = 6;

   typedef logic [NB_INSTR-1:0]   instr_t;
   typedef logic [NB_OPCODE-1:0]  opcode_t;
   typedef logic [NB_FUNCT-1:0]   funct_t;
   typedef logic [NB_REG_IDX-1:0] reg_idx_t;

   localparam opcode_t OP_SPECIAL = 6'd0;
   localparam opcode_t OP_J       = 6'd2;
   localparam opcode_t OP_JAL     = 6'd3;
   localparam opcode_t OP_BEQ     = 6'd4;
   localparam opcode_t OP_BNE     = 6'd5;
   localparam opcode_t OP_ADDI    = 6'd8;
   localparam opcode_t OP_SLTI    = 6'd10;
   localparam opcode_t OP_ANDI    = 6'd12;
   localparam opcode_t OP_ORI     = 6'd13;
   localparam opcode_t OP_XORI    = 6'd14;
   localparam opcode_t OP_LUI     = 6'd15;
   localparam opcode_t OP_LB      = 6'd32;
   localparam opcode_t OP_LH      = 6'd33;
   localparam opcode_t OP_LW      = 6'd35;
   localparam opcode_t OP_LBU     = 6'd36;
   localparam opcode_t OP_LHU     = 6'd37;
   localparam opcode_t OP_LWU     = 6'd39;
   localparam opcode_t OP_SB      = 6'd40;
   localparam opcode_t OP_SH      = 6'd41;
   localparam opcode_t OP_SW      = 6'd43;

   // special opcode function codes
   localparam funct_t FN_SLL  = 6'd0;
   localparam funct_t FN_SRL  = 6'd2;
   localparam funct_t FN_SRA  = 6'd3;
   localparam funct_t FN_JR   = 6'd8;
   localparam funct_t FN_JALR = 6'd9;

endpackage

`default_nettype wire

// File: hw/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

   // immediate extension kind
   typedef logic [1:0] ext_kind_t;
   localparam ext_kind_t EXT_JUMP  = 2'd0; // 26 bit index, zero filled
   localparam ext_kind_t EXT_SIGN  = 2'd1;
   localparam ext_kind_t EXT_ZERO  = 2'd2;
   localparam ext_kind_t EXT_SHAMT = 2'd3; // bits 10..6, zero filled

   typedef logic [3:0] alu_op_t;
   localparam alu_op_t ALU_NONE = 4'd0;
   localparam alu_op_t ALU_ADD  = 4'd1;
   localparam alu_op_t ALU_SLT  = 4'd2;
   localparam alu_op_t ALU_AND  = 4'd3;
   localparam alu_op_t ALU_OR   = 4'd4;
   localparam alu_op_t ALU_XOR  = 4'd5;
   localparam alu_op_t ALU_LUI  = 4'd6;
   localparam alu_op_t ALU_LINK = 4'd7; // return address
   localparam alu_op_t ALU_FUNC = 4'd8; // execute decodes funct

   // alu operand a / b sources
   typedef logic [1:0] a_sel_t;
   localparam a_sel_t A_PC    = 2'd0;
   localparam a_sel_t A_RS    = 2'd1;
   localparam a_sel_t A_SHAMT = 2'd2;
   localparam a_sel_t A_NONE  = 2'd3;

   typedef logic b_sel_t;
   localparam b_sel_t B_RT  = 1'b0;
   localparam b_sel_t B_IMM = 1'b1;

   typedef logic [1:0] dest_sel_t;
   localparam dest_sel_t DEST_RD  = 2'd0;
   localparam dest_sel_t DEST_RT  = 2'd1;
   localparam dest_sel_t DEST_R31 = 2'd2;

   // access size, same code for read and write
   typedef logic [1:0] mem_size_t;
   localparam mem_size_t MEM_OFF  = 2'd0;
   localparam mem_size_t MEM_BYTE = 2'd1;
   localparam mem_size_t MEM_HALF = 2'd2;
   localparam mem_size_t MEM_WORD = 2'd3;

   typedef logic [1:0] wb_src_t;
   localparam wb_src_t WB_ALU   = 2'd0;
   localparam wb_src_t WB_MEM   = 2'd1;
   localparam wb_src_t WB_SBYTE = 2'd2; // sign extended byte load
   localparam wb_src_t WB_SHALF = 2'd3; // sign extended half load

endpackage

`default_nettype wire

// File: hw/decode_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl (
   input  isa_pkg::opcode_t     i_opcode,
   input  isa_pkg::funct_t      i_funct,
   output ctrl_pkg::ext_kind_t  o_ext_kind,
   output ctrl_pkg::alu_op_t    o_alu_op,
   output ctrl_pkg::a_sel_t     o_a_sel,
   output ctrl_pkg::b_sel_t     o_b_sel,
   output ctrl_pkg::dest_sel_t  o_dest_sel,
   output ctrl_pkg::mem_size_t  o_mem_rd,
   output ctrl_pkg::mem_size_t  o_mem_wr,
   output ctrl_pkg::wb_src_t    o_wb_src,
   output logic                 o_wb_en,
   output logic                 o_beq,
   output logic                 o_bne,
   output logic                 o_jump,
   output logic                 o_reg_jump
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   logic special_jump; // jr or jalr

   assign special_jump = (i_funct == FN_JR) || (i_funct == FN_JALR);

   always_comb begin
      // inactive instruction unless a row says otherwise
      o_ext_kind = EXT_SIGN;
      o_alu_op   = ALU_NONE;
      o_a_sel    = A_NONE;
      o_b_sel    = B_IMM;
      o_dest_sel = DEST_RD;
      o_mem_rd   = MEM_OFF;
      o_mem_wr   = MEM_OFF;
      o_wb_src   = WB_ALU;
      o_wb_en    = 1'b0;
      o_beq      = 1'b0;
      o_bne      = 1'b0;
      o_jump     = 1'b0;
      o_reg_jump = 1'b0;

      case (i_opcode)
         OP_J, OP_JAL: begin
            o_ext_kind = EXT_JUMP;
            o_jump     = 1'b1;
            if (i_opcode == OP_JAL) begin // link into r31
               o_alu_op   = ALU_LINK;
               o_a_sel    = A_PC;
               o_dest_sel = DEST_R31;
               o_wb_en    = 1'b1;
            end
         end
         OP_BEQ: o_beq = 1'b1;
         OP_BNE: o_bne = 1'b1;
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
            o_a_sel    = A_RS;
            o_dest_sel = DEST_RT;
            o_wb_en    = 1'b1;
            case (i_opcode)
               OP_ADDI: o_alu_op = ALU_ADD;
               OP_SLTI: o_alu_op = ALU_SLT;
               OP_ANDI: o_alu_op = ALU_AND;
               OP_ORI:  o_alu_op = ALU_OR;
               default: o_alu_op = ALU_XOR;
            endcase
            // logical ops take the immediate unsigned
            if (i_opcode != OP_ADDI && i_opcode != OP_SLTI) begin
               o_ext_kind = EXT_ZERO;
            end
         end
         OP_LUI: begin
            o_ext_kind = EXT_ZERO;
            o_alu_op   = ALU_LUI;
            o_dest_sel = DEST_RT;
            o_wb_en    = 1'b1;
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
            o_alu_op   = ALU_ADD; // base + offset
            o_a_sel    = A_RS;
            o_dest_sel = DEST_RT;
            o_wb_en    = 1'b1;
            o_wb_src   = WB_MEM;
            case (i_opcode)
               OP_LB:   o_mem_rd = MEM_BYTE;
               OP_LBU:  o_mem_rd = MEM_BYTE;
               OP_LH:   o_mem_rd = MEM_HALF;
               OP_LHU:  o_mem_rd = MEM_HALF;
               default: o_mem_rd = MEM_WORD;
            endcase
            if (i_opcode == OP_LB) o_wb_src = WB_SBYTE;
            if (i_opcode == OP_LH) o_wb_src = WB_SHALF;
         end
         OP_SB, OP_SH, OP_SW: begin
            o_alu_op   = ALU_ADD;
            o_a_sel    = A_RS;
            o_dest_sel = DEST_RT;
            o_wb_src   = WB_MEM;
            case (i_opcode)
               OP_SB:   o_mem_wr = MEM_BYTE;
               OP_SH:   o_mem_wr = MEM_HALF;
               default: o_mem_wr = MEM_WORD;
            endcase
         end
         OP_SPECIAL: begin
            o_ext_kind = EXT_SHAMT;
            o_alu_op   = ALU_FUNC;
            o_b_sel    = B_RT;
            o_dest_sel = DEST_RD;
            case (i_funct)
               FN_JALR:                 o_a_sel = A_PC;
               FN_SLL, FN_SRL, FN_SRA:  o_a_sel = A_SHAMT;
               default:                 o_a_sel = A_RS;
            endcase
            o_jump     = special_jump;
            o_reg_jump = special_jump;
            // funct 0 with zero fields is the nop encoding
            o_wb_en    = !(i_funct == FN_JR || i_funct == FN_SLL);
         end
         default: ; // unknown opcodes stay inactive
      endcase
   end

   // the execute stage assumes a single control flow kind per instruction
   always_comb begin
      a_flow_onehot: assert ($onehot0({o_beq, o_bne, o_jump}))
         else $error("decode_ctrl: several control flow flags for opcode %0d", i_opcode);
   end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
   parameter int NB_DATA = 32
) (
   input  logic               i_clk,
   input  logic               i_rst,
   input  isa_pkg::reg_idx_t  i_rs_idx,
   input  isa_pkg::reg_idx_t  i_rt_idx,
   input  isa_pkg::reg_idx_t  i_wr_idx,
   input  logic [NB_DATA-1:0] i_wr_data,
   input  logic               i_wr_en,
   output logic [NB_DATA-1:0] o_rs,
   output logic [NB_DATA-1:0] o_rt
);
   import isa_pkg::*;

   localparam int N_REGS = 2 ** NB_REG_IDX;

   logic [NB_DATA-1:0] regs [N_REGS];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < N_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en && i_wr_idx != '0) begin // r0 is hardwired
         regs[i_wr_idx] <= i_wr_data;
      end
   end

   // no bypass, a read in the write cycle still sees the old value
   assign o_rs = (i_rs_idx == '0) ? '0 : regs[i_rs_idx];
   assign o_rt = (i_rt_idx == '0) ? '0 : regs[i_rt_idx];

endmodule

`default_nettype wire

// File: hw/imm_extend.sv
`timescale 1ns/1ns
`default_nettype none

module imm_extend #(
   parameter int NB_DATA = 32
) (
   input  isa_pkg::instr_t     i_instr,
   input  ctrl_pkg::ext_kind_t i_ext_kind,
   output logic [NB_DATA-1:0]  o_imm
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   always_comb begin
      case (i_ext_kind)
         EXT_JUMP:  o_imm = {{(NB_DATA-NB_INDEX){1'b0}}, i_instr[NB_INDEX-1:0]};
         EXT_SIGN:  o_imm = {{(NB_DATA-NB_IMM){i_instr[NB_IMM-1]}}, i_instr[NB_IMM-1:0]};
         EXT_ZERO:  o_imm = {{(NB_DATA-NB_IMM){1'b0}}, i_instr[NB_IMM-1:0]};
         // shift amount for sll / srl / sra
         EXT_SHAMT: o_imm = {{(NB_DATA-NB_SHAMT){1'b0}}, i_instr[SHAMT_LSB +: NB_SHAMT]};
      endcase
   end

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit #(
   parameter int NB_DATA = 32
) (
   input  logic [NB_DATA-1:0] i_pc,  // already incremented
   input  logic [NB_DATA-1:0] i_imm,
   input  logic [NB_DATA-1:0] i_rs,
   input  logic [NB_DATA-1:0] i_rt,
   input  logic               i_beq,
   input  logic               i_bne,
   input  logic               i_jump,
   input  logic               i_reg_jump,
   output logic [NB_DATA-1:0] o_branch_addr,
   output logic [NB_DATA-1:0] o_jump_addr,
   output logic               o_branch_taken,
   output logic               o_pc_src,
   output logic               o_flush
);
   import isa_pkg::*;

   logic [NB_DATA-1:0] imm_word; // offset in bytes
   logic               operands_equal;
   logic               taken;

   assign imm_word       = i_imm << 2;
   assign operands_equal = (i_rs == i_rt);

   assign o_branch_addr = i_pc + imm_word;

   // jr / jalr take rs, j / jal keep the pc region bits
   assign o_jump_addr = i_reg_jump ? i_rs :
                        {i_pc[NB_DATA-1:NB_JUMP_KEEP], imm_word[NB_JUMP_KEEP-1:0]};

   assign taken          = (i_beq && operands_equal) || (i_bne && !operands_equal);
   assign o_branch_taken = taken;
   assign o_pc_src       = i_jump;
   assign o_flush        = taken || i_jump; // kill the fetched instr

endmodule

`default_nettype wire

// File: hw/id_ex_reg.sv
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg #(
   parameter int NB_DATA = 32
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_bubble,
   input  logic [NB_DATA-1:0]   i_pc,
   input  logic [NB_DATA-1:0]   i_rs,
   input  logic [NB_DATA-1:0]   i_rt,
   input  logic [NB_DATA-1:0]   i_imm,
   input  isa_pkg::funct_t      i_funct,
   input  isa_pkg::reg_idx_t    i_rs_num,
   input  isa_pkg::reg_idx_t    i_rt_num,
   input  isa_pkg::reg_idx_t    i_rd_num,
   input  ctrl_pkg::alu_op_t    i_alu_op,
   input  ctrl_pkg::a_sel_t     i_a_sel,
   input  ctrl_pkg::b_sel_t     i_b_sel,
   input  ctrl_pkg::dest_sel_t  i_dest_sel,
   input  ctrl_pkg::mem_size_t  i_mem_rd,
   input  ctrl_pkg::mem_size_t  i_mem_wr,
   input  logic                 i_wb_en,
   input  ctrl_pkg::wb_src_t    i_wb_src,
   output logic [NB_DATA-1:0]   o_ex_pc,
   output logic [NB_DATA-1:0]   o_ex_rs,
   output logic [NB_DATA-1:0]   o_ex_rt,
   output logic [NB_DATA-1:0]   o_ex_imm,
   output isa_pkg::funct_t      o_ex_funct,
   output isa_pkg::reg_idx_t    o_ex_rs_num,
   output isa_pkg::reg_idx_t    o_ex_rt_num,
   output isa_pkg::reg_idx_t    o_ex_rd_num,
   output ctrl_pkg::alu_op_t    o_ex_alu_op,
   output ctrl_pkg::a_sel_t     o_ex_a_sel,
   output ctrl_pkg::b_sel_t     o_ex_b_sel,
   output ctrl_pkg::dest_sel_t  o_ex_dest_sel,
   output ctrl_pkg::mem_size_t  o_mem_rd,
   output ctrl_pkg::mem_size_t  o_mem_wr,
   output logic                 o_wb_en,
   output ctrl_pkg::wb_src_t    o_wb_src
);
   import ctrl_pkg::*;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_pc       <= '0;
         o_ex_rs       <= '0;
         o_ex_rt       <= '0;
         o_ex_imm      <= '0;
         o_ex_funct    <= '0;
         o_ex_rs_num   <= '0;
         o_ex_rt_num   <= '0;
         o_ex_rd_num   <= '0;
         o_ex_alu_op   <= '0;
         o_ex_a_sel    <= '0;
         o_ex_b_sel    <= '0;
         o_ex_dest_sel <= '0;
         o_mem_rd      <= '0;
         o_mem_wr      <= '0;
         o_wb_en       <= 1'b0;
         o_wb_src      <= '0;
      end else begin
         // data still moves on a bubble
         o_ex_pc       <= i_pc;
         o_ex_rs       <= i_rs;
         o_ex_rt       <= i_rt;
         o_ex_imm      <= i_imm;
         o_ex_funct    <= i_funct;
         o_ex_rs_num   <= i_rs_num;
         o_ex_rt_num   <= i_rt_num;
         o_ex_rd_num   <= i_rd_num;
         // all zero, not the decode defaults
         o_ex_alu_op   <= i_bubble ? '0 : i_alu_op;
         o_ex_a_sel    <= i_bubble ? '0 : i_a_sel;
         o_ex_b_sel    <= i_bubble ? '0 : i_b_sel;
         o_ex_dest_sel <= i_bubble ? '0 : i_dest_sel;
         o_mem_rd      <= i_bubble ? '0 : i_mem_rd;
         o_mem_wr      <= i_bubble ? '0 : i_mem_wr;
         o_wb_en       <= i_bubble ? 1'b0 : i_wb_en;
         o_wb_src      <= i_bubble ? '0 : i_wb_src;
      end
   end

   // a bubble must never reach memory or the register file
   a_bubble_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
      i_bubble |=> (!o_wb_en && o_mem_rd == MEM_OFF && o_mem_wr == MEM_OFF))
      else $error("id_ex_reg: side effect leaked through a bubble");

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage #(
   parameter int NB_DATA = 32
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic [NB_DATA-1:0]   i_pc,  // pc + 4 from fetch
   input  isa_pkg::instr_t      i_instr,
   input  logic [NB_DATA-1:0]   i_wb_data,
   input  isa_pkg::reg_idx_t    i_wb_dst,
   input  logic                 i_wb_en,
   input  logic                 i_bubble,
   output logic [NB_DATA-1:0]   o_ex_pc,
   output logic [NB_DATA-1:0]   o_ex_rs,
   output logic [NB_DATA-1:0]   o_ex_rt,
   output logic [NB_DATA-1:0]   o_ex_imm,
   output isa_pkg::funct_t      o_ex_funct,
   output isa_pkg::reg_idx_t    o_ex_rs_num,
   output isa_pkg::reg_idx_t    o_ex_rt_num,
   output isa_pkg::reg_idx_t    o_ex_rd_num,
   output ctrl_pkg::alu_op_t    o_ex_alu_op,
   output ctrl_pkg::a_sel_t     o_ex_a_sel,
   output ctrl_pkg::b_sel_t     o_ex_b_sel,
   output ctrl_pkg::dest_sel_t  o_ex_dest_sel,
   output ctrl_pkg::mem_size_t  o_mem_rd,
   output ctrl_pkg::mem_size_t  o_mem_wr,
   output logic                 o_wb_en,
   output ctrl_pkg::wb_src_t    o_wb_src,
   output logic [NB_DATA-1:0]   o_branch_addr,
   output logic [NB_DATA-1:0]   o_jump_addr,
   output logic                 o_branch_taken,
   output logic                 o_pc_src,
   output logic                 o_flush,
   output logic                 o_is_branch,
   output logic                 o_is_reg_jump
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   // instruction fields
   opcode_t  opcode;
   funct_t   funct;
   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   reg_idx_t rd_idx;

   // decoded controls
   ext_kind_t ext_kind;
   alu_op_t   alu_op;
   a_sel_t    a_sel;
   b_sel_t    b_sel;
   dest_sel_t dest_sel;
   mem_size_t mem_rd;
   mem_size_t mem_wr;
   wb_src_t   wb_src;
   logic      wb_en;
   logic      beq;
   logic      bne;
   logic      jump;
   logic      reg_jump;

   logic [NB_DATA-1:0] imm;
   logic [NB_DATA-1:0] rs_val;
   logic [NB_DATA-1:0] rt_val;

   assign opcode = i_instr[OPCODE_LSB +: NB_OPCODE];
   assign funct  = i_instr[NB_FUNCT-1:0];
   assign rs_idx = i_instr[RS_LSB +: NB_REG_IDX];
   assign rt_idx = i_instr[RT_LSB +: NB_REG_IDX];
   assign rd_idx = i_instr[RD_LSB +: NB_REG_IDX];

   // hazard unit needs these before the edge
   assign o_is_branch   = beq || bne;
   assign o_is_reg_jump = reg_jump;

   decode_ctrl u_decode_ctrl (
      .i_opcode   (opcode),
      .i_funct    (funct),
      .o_ext_kind (ext_kind),
      .o_alu_op   (alu_op),
      .o_a_sel    (a_sel),
      .o_b_sel    (b_sel),
      .o_dest_sel (dest_sel),
      .o_mem_rd   (mem_rd),
      .o_mem_wr   (mem_wr),
      .o_wb_src   (wb_src),
      .o_wb_en    (wb_en),
      .o_beq      (beq),
      .o_bne      (bne),
      .o_jump     (jump),
      .o_reg_jump (reg_jump)
   );

   reg_file #(.NB_DATA(NB_DATA)) u_reg_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_idx  (rs_idx),
      .i_rt_idx  (rt_idx),
      .i_wr_idx  (i_wb_dst),
      .i_wr_data (i_wb_data),
      .i_wr_en   (i_wb_en),
      .o_rs      (rs_val),
      .o_rt      (rt_val)
   );

   imm_extend #(.NB_DATA(NB_DATA)) u_imm_extend (
      .i_instr    (i_instr),
      .i_ext_kind (ext_kind),
      .o_imm      (imm)
   );

   branch_unit #(.NB_DATA(NB_DATA)) u_branch_unit (
      .i_pc           (i_pc),
      .i_imm          (imm),
      .i_rs           (rs_val),
      .i_rt           (rt_val),
      .i_beq          (beq),
      .i_bne          (bne),
      .i_jump         (jump),
      .i_reg_jump     (reg_jump),
      .o_branch_addr  (o_branch_addr),
      .o_jump_addr    (o_jump_addr),
      .o_branch_taken (o_branch_taken),
      .o_pc_src       (o_pc_src),
      .o_flush        (o_flush)
   );

   id_ex_reg #(.NB_DATA(NB_DATA)) u_id_ex_reg (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_bubble      (i_bubble),
      .i_pc          (i_pc),
      .i_rs          (rs_val),
      .i_rt          (rt_val),
      .i_imm         (imm),
      .i_funct       (funct),
      .i_rs_num      (rs_idx),
      .i_rt_num      (rt_idx),
      .i_rd_num      (rd_idx),
      .i_alu_op      (alu_op),
      .i_a_sel       (a_sel),
      .i_b_sel       (b_sel),
      .i_dest_sel    (dest_sel),
      .i_mem_rd      (mem_rd),
      .i_mem_wr      (mem_wr),
      .i_wb_en       (wb_en),
      .i_wb_src      (wb_src),
      .o_ex_pc       (o_ex_pc),
      .o_ex_rs       (o_ex_rs),
      .o_ex_rt       (o_ex_rt),
      .o_ex_imm      (o_ex_imm),
      .o_ex_funct    (o_ex_funct),
      .o_ex_rs_num   (o_ex_rs_num),
      .o_ex_rt_num   (o_ex_rt_num),
      .o_ex_rd_num   (o_ex_rd_num),
      .o_ex_alu_op   (o_ex_alu_op),
      .o_ex_a_sel    (o_ex_a_sel),
      .o_ex_b_sel    (o_ex_b_sel),
      .o_ex_dest_sel (o_ex_dest_sel),
      .o_mem_rd      (o_mem_rd),
      .o_mem_wr      (o_mem_wr),
      .o_wb_en       (o_wb_en),
      .o_wb_src      (o_wb_src)
   );

endmodule

`default_nettype wire

// File: verif/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// one row of the expected decode table
typedef struct packed {
   ext_kind_t ext_kind;
   alu_op_t   alu_op;
   a_sel_t    a_sel;
   b_sel_t    b_sel;
   dest_sel_t dest_sel;
   mem_size_t mem_rd;
   mem_size_t mem_wr;
   wb_src_t   wb_src;
   logic      wb_en;
   logic      beq;
   logic      bne;
   logic      jump;
   logic      reg_jump;
} ctrl_row_t;

function automatic ctrl_row_t decode_row(input opcode_t op, input funct_t fn);
   ctrl_row_t r;
   r          = '0;
   r.ext_kind = EXT_SIGN; // inactive row
   r.alu_op   = ALU_NONE;
   r.a_sel    = A_NONE;
   r.b_sel    = B_IMM;
   r.dest_sel = DEST_RD;
   r.mem_rd   = MEM_OFF;
   r.mem_wr   = MEM_OFF;
   r.wb_src   = WB_ALU;
   case (op)
      OP_J: begin
         r.ext_kind = EXT_JUMP;
         r.jump     = 1'b1;
      end
      OP_JAL: begin
         r.ext_kind = EXT_JUMP;
         r.jump     = 1'b1;
         r.alu_op   = ALU_LINK;
         r.a_sel    = A_PC;
         r.dest_sel = DEST_R31;
         r.wb_en    = 1'b1;
      end
      OP_BEQ: r.beq = 1'b1;
      OP_BNE: r.bne = 1'b1;
      OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
         r.a_sel    = A_RS;
         r.dest_sel = DEST_RT;
         r.wb_en    = 1'b1;
         r.ext_kind = (op == OP_ADDI || op == OP_SLTI) ? EXT_SIGN : EXT_ZERO;
         if (op == OP_ADDI) r.alu_op = ALU_ADD;
         if (op == OP_SLTI) r.alu_op = ALU_SLT;
         if (op == OP_ANDI) r.alu_op = ALU_AND;
         if (op == OP_ORI)  r.alu_op = ALU_OR;
         if (op == OP_XORI) r.alu_op = ALU_XOR;
      end
      OP_LUI: begin
         r.ext_kind = EXT_ZERO;
         r.alu_op   = ALU_LUI;
         r.dest_sel = DEST_RT;
         r.wb_en    = 1'b1;
      end
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
         r.alu_op   = ALU_ADD;
         r.a_sel    = A_RS;
         r.dest_sel = DEST_RT;
         r.wb_en    = 1'b1;
         r.mem_rd   = (op == OP_LB || op == OP_LBU) ? MEM_BYTE :
                      (op == OP_LH || op == OP_LHU) ? MEM_HALF : MEM_WORD;
         r.wb_src   = (op == OP_LB) ? WB_SBYTE : (op == OP_LH) ? WB_SHALF : WB_MEM;
      end
      OP_SB, OP_SH, OP_SW: begin
         r.alu_op   = ALU_ADD;
         r.a_sel    = A_RS;
         r.dest_sel = DEST_RT;
         r.wb_src   = WB_MEM; // no write though
         r.mem_wr   = (op == OP_SB) ? MEM_BYTE : (op == OP_SH) ? MEM_HALF : MEM_WORD;
      end
      OP_SPECIAL: begin
         r.ext_kind = EXT_SHAMT;
         r.alu_op   = ALU_FUNC;
         r.b_sel    = B_RT;
         r.a_sel    = (fn == FN_JALR) ? A_PC :
                      (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) ? A_SHAMT : A_RS;
         r.jump     = (fn == FN_JR || fn == FN_JALR);
         r.reg_jump = r.jump;
         r.wb_en    = (fn != FN_JR && fn != 6'd0);
      end
      default: ;
   endcase
   return r;
endfunction

// shadow copy of the register file
logic [NB_DATA-1:0] shadow_regs [32];

function automatic logic [NB_DATA-1:0] shadow_read(input reg_idx_t idx);
   return (idx == 5'd0) ? '0 : shadow_regs[idx];
endfunction

task automatic shadow_write(input reg_idx_t idx, input logic [NB_DATA-1:0] data, input logic en);
   if (en && idx != 5'd0) begin
      shadow_regs[idx] = data;
   end
endtask

`endif

// File: verif/tb_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decode_stage;
   import isa_pkg::*;
   import ctrl_pkg::*;

   localparam int NB_DATA       = 32;
   localparam int CLK_PERIOD    = 4;
   localparam int RESET_CYCLES  = 10;
   localparam int RESET_TIMEOUT = 100;
   localparam int N_CYCLES      = 2000;

   localparam opcode_t LEGAL_OPS [20] = '{OP_SPECIAL, OP_J, OP_JAL, OP_BEQ, OP_BNE,
      OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW,
      OP_LBU, OP_LHU, OP_LWU, OP_SB, OP_SH, OP_SW};
   localparam funct_t SPECIAL_FUNCTS [5] = '{FN_SLL, FN_SRL, FN_SRA, FN_JR, FN_JALR};

   logic               i_clk;
   logic               i_rst;
   logic [NB_DATA-1:0] i_pc;
   instr_t             i_instr;
   logic [NB_DATA-1:0] i_wb_data;
   reg_idx_t           i_wb_dst;
   logic               i_wb_en;
   logic               i_bubble;

   logic [NB_DATA-1:0] o_ex_pc;
   logic [NB_DATA-1:0] o_ex_rs;
   logic [NB_DATA-1:0] o_ex_rt;
   logic [NB_DATA-1:0] o_ex_imm;
   funct_t             o_ex_funct;
   reg_idx_t           o_ex_rs_num;
   reg_idx_t           o_ex_rt_num;
   reg_idx_t           o_ex_rd_num;
   alu_op_t            o_ex_alu_op;
   a_sel_t             o_ex_a_sel;
   b_sel_t             o_ex_b_sel;
   dest_sel_t          o_ex_dest_sel;
   mem_size_t          o_mem_rd;
   mem_size_t          o_mem_wr;
   logic               o_wb_en;
   wb_src_t            o_wb_src;
   logic [NB_DATA-1:0] o_branch_addr;
   logic [NB_DATA-1:0] o_jump_addr;
   logic               o_branch_taken;
   logic               o_pc_src;
   logic               o_flush;
   logic               o_is_branch;
   logic               o_is_reg_jump;

   `include "decode_model.svh"

   int                 seed = 43315;
   int                 error_count = 0;
   int                 cycle_count = 0;
   logic               released;

   // what the ID/EX register should hold after the next edge
   ctrl_row_t          pend_row;
   logic [NB_DATA-1:0] pend_pc;
   logic [NB_DATA-1:0] pend_rs;
   logic [NB_DATA-1:0] pend_rt;
   logic [NB_DATA-1:0] pend_imm;
   instr_t             pend_instr;

   decode_stage #(.NB_DATA(NB_DATA)) i_decode_stage (.*);

   initial i_clk = 1'b0;
   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   initial begin : reset_driver
      i_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge i_clk);
      i_rst <= 1'b0;
   end

   task automatic flag_mismatch(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
      error_count++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
   endtask

   function automatic logic [NB_DATA-1:0] extend_imm(input instr_t ins, input ext_kind_t kind);
      case (kind)
         EXT_JUMP: return {{(NB_DATA-26){1'b0}}, ins[25:0]};
         EXT_SIGN: return {{(NB_DATA-16){ins[15]}}, ins[15:0]};
         EXT_ZERO: return {{(NB_DATA-16){1'b0}}, ins[15:0]};
         default:  return {{(NB_DATA-5){1'b0}}, ins[10:6]}; // shamt
      endcase
   endfunction

   task automatic wait_reset_release(output logic done);
      int cycles;
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < RESET_TIMEOUT) begin
         @(negedge i_clk);
         cycles++;
         if (i_rst === 1'b0) done = 1'b1;
      end
   endtask

   task automatic drive_idle();
      i_instr   <= '0;
      i_pc      <= '0;
      i_wb_data <= '0;
      i_wb_dst  <= '0;
      i_wb_en   <= 1'b0;
      i_bubble  <= 1'b1;
   endtask

   task automatic drive_random();
      instr_t ins;
      int     pick;
      ins  = $random(seed);
      pick = $unsigned($random(seed)) % 21;
      // pick 20 takes any opcode and mostly lands on an undecoded one
      ins[31:26] = (pick == 20) ? opcode_t'($random(seed)) : LEGAL_OPS[pick];
      if (ins[31:26] == OP_SPECIAL) begin
         pick      = $unsigned($random(seed)) % 6;
         ins[5:0] = (pick == 5) ? funct_t'($random(seed)) : SPECIAL_FUNCTS[pick];
      end
      if (($random(seed) & 3) == 0) ins[20:16] = ins[25:21]; // equal operands
      i_instr   <= ins;
      i_pc      <= NB_DATA'($random(seed));
      i_wb_dst  <= (($random(seed) & 7) == 0) ? reg_idx_t'(0) : reg_idx_t'($random(seed));
      i_wb_data <= NB_DATA'($random(seed));
      i_wb_en   <= 1'($random(seed));
      i_bubble  <= (($random(seed) & 7) == 0);
   endtask

   task automatic check_reset_state();
      if (o_wb_en !== 1'b0) flag_mismatch("o_wb_en after reset", o_wb_en, 0);
      if (o_mem_rd !== MEM_OFF) flag_mismatch("o_mem_rd after reset", o_mem_rd, 0);
      if (o_mem_wr !== MEM_OFF) flag_mismatch("o_mem_wr after reset", o_mem_wr, 0);
      if (o_ex_pc !== '0) flag_mismatch("o_ex_pc after reset", o_ex_pc, 0);
      if (o_ex_rs !== '0) flag_mismatch("o_ex_rs after reset", o_ex_rs, 0);
      if (o_ex_rt !== '0) flag_mismatch("o_ex_rt after reset", o_ex_rt, 0);
      if (o_ex_imm !== '0) flag_mismatch("o_ex_imm after reset", o_ex_imm, 0);
   endtask

   // branch and jump outputs, then the values for the coming edge
   task automatic check_same_cycle();
      ctrl_row_t          row;
      logic [NB_DATA-1:0] rs_v;
      logic [NB_DATA-1:0] rt_v;
      logic [NB_DATA-1:0] imm_v;
      logic [NB_DATA-1:0] target;
      logic               taken;
      row   = decode_row(i_instr[31:26], i_instr[5:0]);
      rs_v  = shadow_read(i_instr[25:21]);
      rt_v  = shadow_read(i_instr[20:16]);
      imm_v = extend_imm(i_instr, row.ext_kind);
      taken = (row.beq && rs_v == rt_v) || (row.bne && rs_v != rt_v);
      if (o_branch_taken !== taken) flag_mismatch("o_branch_taken", o_branch_taken, taken);
      if (o_is_branch !== (row.beq || row.bne))
         flag_mismatch("o_is_branch", o_is_branch, row.beq || row.bne);
      if (o_pc_src !== row.jump) flag_mismatch("o_pc_src", o_pc_src, row.jump);
      if (o_is_reg_jump !== row.reg_jump)
         flag_mismatch("o_is_reg_jump", o_is_reg_jump, row.reg_jump);
      if (o_flush !== (taken || row.jump)) flag_mismatch("o_flush", o_flush, taken || row.jump);
      target = i_pc + (imm_v << 2);
      if ((row.beq || row.bne) && o_branch_addr !== target)
         flag_mismatch("o_branch_addr", o_branch_addr, target);
      target = imm_v << 2;
      target = row.reg_jump ? rs_v : {i_pc[NB_DATA-1:28], target[27:0]};
      if (row.jump && o_jump_addr !== target) flag_mismatch("o_jump_addr", o_jump_addr, target);

      pend_row   = i_bubble ? '0 : row;
      pend_pc    = i_pc;
      pend_rs    = rs_v; // read before this cycle's write lands
      pend_rt    = rt_v;
      pend_imm   = imm_v;
      pend_instr = i_instr;
   endtask

   task automatic check_latched();
      if (o_ex_alu_op !== pend_row.alu_op) flag_mismatch("o_ex_alu_op", o_ex_alu_op, pend_row.alu_op);
      if (o_ex_a_sel !== pend_row.a_sel) flag_mismatch("o_ex_a_sel", o_ex_a_sel, pend_row.a_sel);
      if (o_ex_b_sel !== pend_row.b_sel) flag_mismatch("o_ex_b_sel", o_ex_b_sel, pend_row.b_sel);
      if (o_ex_dest_sel !== pend_row.dest_sel)
         flag_mismatch("o_ex_dest_sel", o_ex_dest_sel, pend_row.dest_sel);
      if (o_mem_rd !== pend_row.mem_rd) flag_mismatch("o_mem_rd", o_mem_rd, pend_row.mem_rd);
      if (o_mem_wr !== pend_row.mem_wr) flag_mismatch("o_mem_wr", o_mem_wr, pend_row.mem_wr);
      if (o_wb_en !== pend_row.wb_en) flag_mismatch("o_wb_en", o_wb_en, pend_row.wb_en);
      if (o_wb_src !== pend_row.wb_src) flag_mismatch("o_wb_src", o_wb_src, pend_row.wb_src);
      if (o_ex_pc !== pend_pc) flag_mismatch("o_ex_pc", o_ex_pc, pend_pc);
      if (o_ex_rs !== pend_rs) flag_mismatch("o_ex_rs", o_ex_rs, pend_rs);
      if (o_ex_rt !== pend_rt) flag_mismatch("o_ex_rt", o_ex_rt, pend_rt);
      if (o_ex_imm !== pend_imm) flag_mismatch("o_ex_imm", o_ex_imm, pend_imm);
      if (o_ex_funct !== pend_instr[5:0]) flag_mismatch("o_ex_funct", o_ex_funct, pend_instr[5:0]);
      if (o_ex_rs_num !== pend_instr[25:21])
         flag_mismatch("o_ex_rs_num", o_ex_rs_num, pend_instr[25:21]);
      if (o_ex_rt_num !== pend_instr[20:16])
         flag_mismatch("o_ex_rt_num", o_ex_rt_num, pend_instr[20:16]);
      if (o_ex_rd_num !== pend_instr[15:11])
         flag_mismatch("o_ex_rd_num", o_ex_rd_num, pend_instr[15:11]);
   endtask

   initial begin : main
      // a live load during reset, so only the reset clears the ID/EX outputs
      i_pc      = '1;
      i_instr   = {OP_LW, 5'd1, 5'd2, 16'h8004};
      i_wb_data = '0;
      i_wb_dst  = '0;
      i_wb_en   = 1'b0;
      i_bubble  = 1'b0;
      for (int i = 0; i < 32; i++) begin
         shadow_regs[i] = '0;
      end

      wait_reset_release(released);
      if (released) begin
         check_reset_state();
         for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            @(posedge i_clk);
            drive_random();
            @(negedge i_clk);
            if (cyc > 0) check_latched();
            check_same_cycle();
            shadow_write(i_wb_dst, i_wb_data, i_wb_en);
            cycle_count++;
         end
         @(posedge i_clk);
         drive_idle();
         @(negedge i_clk);
         check_latched(); // last instruction
         $display("cycles checked: %0d, errors: %0d", cycle_count, error_count);
         if (error_count == 0) begin
            $display("Test OK");
         end else begin
            $display("Test FAILED");
         end
      end else begin
         $display("reset was still asserted after %0d cycles", RESET_TIMEOUT);
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verif
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/decode_ctrl.sv
hw/reg_file.sv
hw/imm_extend.sv
hw/branch_unit.sv
hw/id_ex_reg.sv
hw/decode_stage.sv
verif/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# build the decode stage testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
   --top-module tb_decode_stage -Mdir obj_dir
./obj_dir/Vtb_decode_stage > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
   exit 1
fi
